//--- us_pkg.sv
/* shared widths, types and register map of the 8-channel front end
   all lengths and delays count ADC_CLKOUT cycles, a zero length skips its phase */
package us_pkg;

	// ==============================
	// widths and types
	// ==============================
	localparam int NUM_CH      = 8;	// transducer and adc channels
	localparam int SAMPLE_W    = 14;	// adc resolution
	localparam int START_DELAY = 10;	// start write edge to trig
	localparam int START_CNT_W = $clog2(START_DELAY + 1);

	typedef logic [SAMPLE_W-1:0]    sample_t;
	typedef sample_t [NUM_CH-1:0]   frame_t;	// ch0 in the low bits
	typedef logic [NUM_CH-1:0]      ch_mask_t;	// one bit per channel
	typedef logic [15:0]            acq_len_t;	// acq delay, samples per echo
	typedef logic [7:0]             pulse_len_t;	// tx delay, drive, damp
	typedef logic [2:0]             reg_addr_t;
	typedef logic [31:0]            reg_data_t;
	typedef logic [START_CNT_W-1:0] start_cnt_t;

	// ==============================
	// register map
	// ==============================
	localparam reg_addr_t ADDR_CTRL        = 3'd0;	// bit 0 start, write only
	localparam reg_addr_t ADDR_ACQ_DELAY   = 3'd1;
	localparam reg_addr_t ADDR_ACQ_SAMPLES = 3'd2;
	localparam reg_addr_t ADDR_TX_DELAY    = 3'd3;
	localparam reg_addr_t ADDR_TX_LEN      = 3'd4;
	localparam reg_addr_t ADDR_DAMP_LEN    = 3'd5;
	localparam reg_addr_t ADDR_TX_MASK     = 3'd6;
	localparam reg_addr_t ADDR_STATUS      = 3'd7;	// {overflow, busy, done}

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_DELAY,
		TX_DRIVE,	// txp active
		TX_DAMP	// txn active
	} tx_state_t;

	typedef enum logic [1:0] {
		ACQ_IDLE,
		ACQ_DELAY,
		ACQ_WINDOW	// frames captured
	} acq_state_t;

endpackage

//--- us_cfg_if.sv
/* register values and trigger from the register bank to pulser and sequencer
   fields may change at any time, the consumers sample them at phase starts */
`timescale 1ns/100ps

interface us_cfg_if
	import us_pkg::*;
();

	acq_len_t   acq_delay;	// cycles from trig to window
	acq_len_t   acq_samples;	// window length in frames
	pulse_len_t tx_delay;
	pulse_len_t tx_len;
	pulse_len_t damp_len;
	ch_mask_t   tx_mask;
	logic       trig;	// one-cycle shot trigger

	modport regs (output acq_delay, acq_samples, tx_delay, tx_len, damp_len, tx_mask, trig);
	modport pulser (input tx_delay, tx_len, damp_len, tx_mask, trig);
	modport sequencer (input acq_delay, acq_samples, trig);

endinterface

//--- us_cfg_regs.sv
/* host register bank, writes act on the clock edge, reads are combinational
   a start is taken only when no shot is pending or running */
`timescale 1ns/100ps

module us_cfg_regs
	import us_pkg::*;
(
	input  logic      ADC_CLKOUT,
	input  logic      rst,
	input  logic      reg_wr,
	input  reg_addr_t reg_addr,
	input  reg_data_t reg_wdata,
	output reg_data_t reg_rdata,
	input  logic      busy,	// sequencer shot running
	input  logic      done,	// sequencer end of window pulse
	input  logic      overflow,	// sticky drop flag from stream
	us_cfg_if.regs    cfg
);

	start_cnt_t start_cnt;	// cycles left to trig, zero when idle
	logic       pending;
	logic       start_ok;
	logic       done_flag;	// sticky until next accepted start
	logic       busy_rpt;
	logic       done_rpt;

	assign pending  = (start_cnt != '0) || cfg.trig;	// covers gap until sequencer busy
	assign start_ok = reg_wr && (reg_addr == ADDR_CTRL) && reg_wdata[0] && !busy && !pending;
	assign busy_rpt = busy || pending;
	assign done_rpt = done_flag || done;	// no gap between busy fall and done

	// ==============================
	// configuration registers
	// ==============================
	always_ff @(posedge ADC_CLKOUT)
	begin
		if (rst)
		begin
			cfg.acq_delay   <= '0;
			cfg.acq_samples <= '0;
			cfg.tx_delay    <= '0;
			cfg.tx_len      <= '0;
			cfg.damp_len    <= '0;
			cfg.tx_mask     <= '0;
		end
		else if (reg_wr)
		begin
			case (reg_addr)
				ADDR_ACQ_DELAY:   cfg.acq_delay   <= reg_wdata[$bits(acq_len_t)-1:0];
				ADDR_ACQ_SAMPLES: cfg.acq_samples <= reg_wdata[$bits(acq_len_t)-1:0];
				ADDR_TX_DELAY:    cfg.tx_delay    <= reg_wdata[$bits(pulse_len_t)-1:0];
				ADDR_TX_LEN:      cfg.tx_len      <= reg_wdata[$bits(pulse_len_t)-1:0];
				ADDR_DAMP_LEN:    cfg.damp_len    <= reg_wdata[$bits(pulse_len_t)-1:0];
				ADDR_TX_MASK:     cfg.tx_mask     <= reg_wdata[$bits(ch_mask_t)-1:0];
				default: ;	// ctrl handled below, status read only
			endcase
		end
	end

	// ==============================
	// start to trig, sticky done
	// ==============================
	always_ff @(posedge ADC_CLKOUT)
	begin
		if (rst)
		begin
			start_cnt <= '0;
			cfg.trig  <= 1'b0;
			done_flag <= 1'b0;
		end
		else
		begin
			cfg.trig <= (start_cnt == start_cnt_t'(1));	// fires START_DELAY edges after write
			if (start_ok)
				start_cnt <= start_cnt_t'(START_DELAY);
			else if (start_cnt != '0)
				start_cnt <= start_cnt - 1'b1;
			if (start_ok)
				done_flag <= 1'b0;
			else if (done)
				done_flag <= 1'b1;
		end
	end

	// read mux, unused bits zero
	always_comb
	begin
		reg_rdata = '0;
		case (reg_addr)
			ADDR_ACQ_DELAY:   reg_rdata[$bits(acq_len_t)-1:0]   = cfg.acq_delay;
			ADDR_ACQ_SAMPLES: reg_rdata[$bits(acq_len_t)-1:0]   = cfg.acq_samples;
			ADDR_TX_DELAY:    reg_rdata[$bits(pulse_len_t)-1:0] = cfg.tx_delay;
			ADDR_TX_LEN:      reg_rdata[$bits(pulse_len_t)-1:0] = cfg.tx_len;
			ADDR_DAMP_LEN:    reg_rdata[$bits(pulse_len_t)-1:0] = cfg.damp_len;
			ADDR_TX_MASK:     reg_rdata[$bits(ch_mask_t)-1:0]   = cfg.tx_mask;
			ADDR_STATUS:      reg_rdata[2:0] = {overflow, busy_rpt, done_rpt};
			default: ;	// ctrl is write only
		endcase
	end

endmodule

//--- us_tx_pulser.sv
/* transmit pulser, delay then drive on txp then damp on txn, masked per channel
   a trig that arrives while a burst runs is ignored */
`timescale 1ns/100ps

module us_tx_pulser
	import us_pkg::*;
(
	input  logic        ADC_CLKOUT,
	input  logic        rst,
	us_cfg_if.pulser    cfg,
	output ch_mask_t    txp,
	output ch_mask_t    txn
);

	tx_state_t  state, state_nxt;
	pulse_len_t cnt, cnt_nxt;	// cycles left in current phase

	always_comb
	begin
		state_nxt = state;
		cnt_nxt   = cnt;
		case (state)
			TX_IDLE:
			begin
				if (cfg.trig)
				begin
					state_nxt = TX_DELAY;
					cnt_nxt   = cfg.tx_delay;
				end
			end
			default: cnt_nxt = cnt - 1'b1;	// never below one in an active phase
		endcase
		// phase ended or zero length, move on in the same cycle
		if (state_nxt == TX_DELAY && cnt_nxt == '0)
		begin
			state_nxt = TX_DRIVE;
			cnt_nxt   = cfg.tx_len;
		end
		if (state_nxt == TX_DRIVE && cnt_nxt == '0)
		begin
			state_nxt = TX_DAMP;
			cnt_nxt   = cfg.damp_len;
		end
		if (state_nxt == TX_DAMP && cnt_nxt == '0)
			state_nxt = TX_IDLE;
	end

	// registered outputs follow the state, txp and txn exclusive by construction
	always_ff @(posedge ADC_CLKOUT)
	begin
		if (rst)
		begin
			state <= TX_IDLE;
			cnt   <= '0;
			txp   <= '0;
			txn   <= '0;
		end
		else
		begin
			state <= state_nxt;
			cnt   <= cnt_nxt;
			txp   <= (state_nxt == TX_DRIVE) ? cfg.tx_mask : '0;
			txn   <= (state_nxt == TX_DAMP) ? cfg.tx_mask : '0;
		end
	end

endmodule

//--- us_acq_sequencer.sv
/* acquisition sequencer, initial delay then a window of acq_samples frames
   busy is high from trig to window end, done is a one-cycle pulse at the end */
`timescale 1ns/100ps

module us_acq_sequencer
	import us_pkg::*;
(
	input  logic         ADC_CLKOUT,
	input  logic         rst,
	us_cfg_if.sequencer  cfg,
	output logic         in_window,	// capture current frame
	output logic         window_first,	// first window cycle
	output logic         busy,
	output logic         done
);

	acq_state_t state, state_nxt;
	acq_len_t   dly_cnt, dly_cnt_nxt;	// delay cycles left
	acq_len_t   win_cnt, win_cnt_nxt;	// window frames left

	assign in_window = (state == ACQ_WINDOW);
	assign busy      = (state != ACQ_IDLE);

	always_comb
	begin
		state_nxt   = state;
		dly_cnt_nxt = dly_cnt;
		win_cnt_nxt = win_cnt;
		case (state)
			ACQ_IDLE:
			begin
				if (cfg.trig)
				begin
					state_nxt   = ACQ_DELAY;
					dly_cnt_nxt = cfg.acq_delay;
				end
			end
			ACQ_DELAY:  dly_cnt_nxt = dly_cnt - 1'b1;
			ACQ_WINDOW: win_cnt_nxt = win_cnt - 1'b1;
			default:    state_nxt = ACQ_IDLE;
		endcase
		// zero lengths fall through
		if (state_nxt == ACQ_DELAY && dly_cnt_nxt == '0)
		begin
			state_nxt   = ACQ_WINDOW;
			win_cnt_nxt = cfg.acq_samples;
		end
		if (state_nxt == ACQ_WINDOW && win_cnt_nxt == '0)
			state_nxt = ACQ_IDLE;
	end

	// ==============================
	// state and flags
	// ==============================
	always_ff @(posedge ADC_CLKOUT)
	begin
		if (rst)
		begin
			state        <= ACQ_IDLE;
			dly_cnt      <= '0;
			win_cnt      <= '0;
			window_first <= 1'b0;
			done         <= 1'b0;
		end
		else
		begin
			state        <= state_nxt;
			dly_cnt      <= dly_cnt_nxt;
			win_cnt      <= win_cnt_nxt;
			window_first <= (state_nxt == ACQ_WINDOW) && (state != ACQ_WINDOW);
			done         <= (busy || cfg.trig) && (state_nxt == ACQ_IDLE);	// also zero-length shot
		end
	end

endmodule

//--- us_sample_stream.sv
/* one-deep output stage on valid/ready, a window frame that finds it full is dropped
   overflow is sticky and clears at the start of the next window */
`timescale 1ns/100ps

module us_sample_stream
	import us_pkg::*;
(
	input  logic   ADC_CLKOUT,
	input  logic   rst,
	input  frame_t adc_frame,
	input  logic   in_window,
	input  logic   window_first,
	output logic   sample_valid,
	input  logic   sample_ready,
	output frame_t sample_data,
	output logic   overflow
);

	logic load;	// take the current frame
	logic drop;	// frame lost to back-pressure

	assign load = in_window && (!sample_valid || sample_ready);	// empty or leaving now
	assign drop = in_window && !load;

	always_ff @(posedge ADC_CLKOUT)
	begin
		if (rst)
		begin
			sample_valid <= 1'b0;
			overflow     <= 1'b0;
		end
		else
		begin
			if (load)
				sample_valid <= 1'b1;
			else if (sample_ready)
				sample_valid <= 1'b0;	// accepted, nothing new
			overflow <= window_first ? drop : (overflow || drop);
		end
	end

	// holding register, steady while stalled
	always_ff @(posedge ADC_CLKOUT)
	begin
		if (rst)
			sample_data <= '0;
		else if (load)
			sample_data <= adc_frame;
	end

endmodule

//--- us_frontend_top.sv
/* ultrasound front end top, everything on ADC_CLKOUT
   adc_frame must carry a new parallel frame every cycle */
`timescale 1ns/100ps

module us_frontend_top
	import us_pkg::*;
(
	input  logic      ADC_CLKOUT,
	input  logic      rst,
	// host word port
	input  logic      reg_wr,
	input  reg_addr_t reg_addr,
	input  reg_data_t reg_wdata,
	output reg_data_t reg_rdata,
	// adc and sample stream
	input  frame_t    adc_frame,
	output logic      sample_valid,
	input  logic      sample_ready,
	output frame_t    sample_data,
	// transmit pairs
	output ch_mask_t  txp,
	output ch_mask_t  txn
);

	logic busy;	// sequencer to regs
	logic done;
	logic overflow;	// stream to regs
	logic in_window;
	logic window_first;

	us_cfg_if cfg ();

	us_cfg_regs u_regs (
		.ADC_CLKOUT (ADC_CLKOUT),
		.rst        (rst),
		.reg_wr     (reg_wr),
		.reg_addr   (reg_addr),
		.reg_wdata  (reg_wdata),
		.reg_rdata  (reg_rdata),
		.busy       (busy),
		.done       (done),
		.overflow   (overflow),
		.cfg        (cfg.regs)
	);

	us_tx_pulser u_pulser (
		.ADC_CLKOUT (ADC_CLKOUT),
		.rst        (rst),
		.cfg        (cfg.pulser),
		.txp        (txp),
		.txn        (txn)
	);

	us_acq_sequencer u_seq (
		.ADC_CLKOUT   (ADC_CLKOUT),
		.rst          (rst),
		.cfg          (cfg.sequencer),
		.in_window    (in_window),
		.window_first (window_first),
		.busy         (busy),
		.done         (done)
	);

	us_sample_stream u_stream (
		.ADC_CLKOUT   (ADC_CLKOUT),
		.rst          (rst),
		.adc_frame    (adc_frame),
		.in_window    (in_window),
		.window_first (window_first),
		.sample_valid (sample_valid),
		.sample_ready (sample_ready),
		.sample_data  (sample_data),
		.overflow     (overflow)
	);

endmodule

//--- tb_clk_gen.sv
/* testbench clock and reset, 8 ns period
   rst is released 1 ns after the 8th rising edge */
`timescale 1ns/100ps

module tb_clk_gen (
	output logic ADC_CLKOUT,
	output logic rst
);

	localparam int HALF_NS    = 4;
	localparam int RST_CYCLES = 8;

	initial
	begin
		ADC_CLKOUT = 1'b0;
		forever #HALF_NS ADC_CLKOUT = ~ADC_CLKOUT;
	end

	initial
	begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge ADC_CLKOUT);
		#1 rst = 1'b0;	// same offset as other stimulus
	end

endmodule

//--- tb_us_frontend.sv
/* random shots through the front end, checked against a cycle model
   stimulus moves 1 ns after the rising edge, outputs are sampled at the falling edge */
`timescale 1ns/100ps

module tb_us_frontend
	import us_pkg::*;
();

	localparam int NUM_SHOTS   = 40;
	localparam int SHOT_CYCLES = 200;	// worst case shot with host traffic
	localparam int WATCHDOG_NS = (NUM_SHOTS * SHOT_CYCLES + 200) * 8;

	logic        ADC_CLKOUT;
	logic        rst;
	logic        reg_wr;
	reg_addr_t   reg_addr;
	reg_data_t   reg_wdata;
	reg_data_t   reg_rdata;
	frame_t      adc_frame;
	logic        sample_valid;
	logic        sample_ready;
	frame_t      sample_data;
	ch_mask_t    txp;
	ch_mask_t    txn;

	int          errors;
	int          checks;
	logic        ready_random;	// back-pressure in this shot
	sample_t     frame_cnt;
	sample_t     acc_q[$];	// ch0 of accepted frames
	logic [15:0] tx_q[$];	// {txp, txn} of active cycles
	int          shot_bursts;
	int          total_bursts;
	int          total_active;
	int          exp_bursts;
	int          exp_active;
	logic        tx_prev_active;
	logic        stalled;
	frame_t      stall_data;

	tb_clk_gen u_clk (
		.ADC_CLKOUT (ADC_CLKOUT),
		.rst        (rst)
	);

	us_frontend_top dut (
		.ADC_CLKOUT   (ADC_CLKOUT),
		.rst          (rst),
		.reg_wr       (reg_wr),
		.reg_addr     (reg_addr),
		.reg_wdata    (reg_wdata),
		.reg_rdata    (reg_rdata),
		.adc_frame    (adc_frame),
		.sample_valid (sample_valid),
		.sample_ready (sample_ready),
		.sample_data  (sample_data),
		.txp          (txp),
		.txn          (txn)
	);

	// ==============================
	// helpers
	// ==============================
	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("ERROR %0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic require_rule(input logic cond, input string what);
		checks++;
		assert (cond)
		else
		begin
			errors++;
			$display("%0t failure: %s", $time, what);
		end
	endtask

	function automatic frame_t make_frame(input sample_t cnt);
		frame_t f;
		for (int k = 0; k < NUM_CH; k++)
			f[k] = cnt + sample_t'(k);	// wraps at 2^14
		return f;
	endfunction

	function automatic reg_data_t field_bits(input reg_addr_t addr);
		case (addr)
			ADDR_ACQ_DELAY, ADDR_ACQ_SAMPLES: return 32'h0000_ffff;
			default:                          return 32'h0000_00ff;
		endcase
	endfunction

	task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
		@(posedge ADC_CLKOUT);
		#1;
		reg_wr    = 1'b1;
		reg_addr  = addr;
		reg_wdata = data;
		@(posedge ADC_CLKOUT);	// write edge
		#1;
		reg_wr = 1'b0;
	endtask

	task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
		@(posedge ADC_CLKOUT);
		#1;
		reg_addr = addr;
		@(negedge ADC_CLKOUT);	// combinational read settled
		data = reg_rdata;
	endtask

	// ==============================
	// stimulus processes
	// ==============================
	initial
	begin
		frame_cnt = '0;
		adc_frame = make_frame(frame_cnt);
		forever
		begin
			@(posedge ADC_CLKOUT);
			#1;
			frame_cnt = frame_cnt + sample_t'(1);	// free-running, one frame per cycle
			adc_frame = make_frame(frame_cnt);
		end
	end

	initial
	begin
		logic mode;
		sample_ready = 1'b0;
		forever
		begin
			@(posedge ADC_CLKOUT);
			mode = ready_random;	// main changes it only after the edge
			#1;
			sample_ready = mode ? ($urandom % 2 == 1) : 1'b1;
		end
	end

	// output monitors
	always @(negedge ADC_CLKOUT)
	begin
		if (!rst)
		begin
			if (stalled)
			begin
				require_rule(sample_valid, "sample_valid dropped while a frame was stalled");
				require_rule(sample_data == stall_data, "sample_data changed while stalled");
			end
			if (sample_valid && sample_ready)
			begin
				acc_q.push_back(sample_data[0]);
				for (int k = 1; k < NUM_CH; k++)
					compare_value($sformatf("sample_data ch%0d", k), 32'(sample_data[k]),
						32'(sample_t'(sample_data[0] + sample_t'(k))));
			end
			stalled    = sample_valid && !sample_ready;
			stall_data = sample_data;
			require_rule((txp & txn) == '0, "txp and txn high in the same cycle");
			if ((txp | txn) != '0)
			begin
				tx_q.push_back({txp, txn});
				total_active++;
				if (!tx_prev_active)
				begin
					shot_bursts++;	// new burst
					total_bursts++;
				end
			end
			tx_prev_active = ((txp | txn) != '0);
		end
	end

	// ==============================
	// one shot with random settings
	// ==============================
	task automatic run_shot();
		reg_data_t val [1:6];	// indexed by register address
		reg_data_t rd;
		logic      back_pressure;
		logic      restart;
		int        samples;
		int        drive_len;
		int        exp_len;
		int        tx_total;
		int        n;
		int        diff;
		ch_mask_t  mask;
		@(negedge ADC_CLKOUT);	// draws clear of the ready driver
		for (int a = 1; a <= 6; a++)
			val[a] = $urandom;	// upper bits test truncation
		val[ADDR_ACQ_DELAY][15:0]   = 16'(1 + $urandom % 40);
		val[ADDR_ACQ_SAMPLES][15:0] = 16'(1 + $urandom % 40);
		val[ADDR_TX_DELAY][7:0]     = 8'($urandom % 13);
		val[ADDR_TX_LEN][7:0]       = 8'($urandom % 13);
		val[ADDR_DAMP_LEN][7:0]     = 8'($urandom % 13);
		back_pressure = ($urandom % 2 == 1);
		restart       = ($urandom % 2 == 1);
		samples   = int'(val[ADDR_ACQ_SAMPLES][15:0]);
		drive_len = int'(val[ADDR_TX_LEN][7:0]);
		mask      = val[ADDR_TX_MASK][7:0];
		exp_len   = (mask != '0) ? drive_len + int'(val[ADDR_DAMP_LEN][7:0]) : 0;
		tx_total  = int'(val[ADDR_TX_DELAY][7:0]) + drive_len + int'(val[ADDR_DAMP_LEN][7:0]);
		@(posedge ADC_CLKOUT);
		#1;
		acc_q.delete();
		tx_q.delete();
		shot_bursts  = 0;
		ready_random = back_pressure;
		for (int a = 1; a <= 6; a++)
			write_reg(reg_addr_t'(a), val[a]);
		for (int a = 1; a <= 6; a++)
		begin
			read_reg(reg_addr_t'(a), rd);
			compare_value($sformatf("reg_rdata[%0d]", a), rd, val[a] & field_bits(reg_addr_t'(a)));
		end
		write_reg(ADDR_CTRL, 32'h1);
		exp_bursts += (exp_len != 0) ? 1 : 0;
		exp_active += exp_len;
		read_reg(ADDR_STATUS, rd);
		compare_value("reg_rdata status busy,done", 32'(rd[1:0]), 32'h2);	// done cleared
		if (restart)
			write_reg(ADDR_CTRL, 32'h1);	// must be ignored
		do
			read_reg(ADDR_STATUS, rd);
		while (!rd[0]);
		ready_random = 1'b0;	// drain with ready high
		while (sample_valid)
			@(negedge ADC_CLKOUT);
		while (tx_q.size() < exp_len)
			@(negedge ADC_CLKOUT);
		if (mask == '0)
			repeat (tx_total) @(negedge ADC_CLKOUT);	// burst runs with no channel active
		read_reg(ADDR_STATUS, rd);
		compare_value("reg_rdata status done", 32'(rd[0]), 32'h1);
		compare_value("reg_rdata status busy", 32'(rd[1]), 32'h0);
		// transmit shape
		compare_value("txp/txn burst count", shot_bursts, (exp_len != 0) ? 1 : 0);
		compare_value("txp/txn active cycles", tx_q.size(), exp_len);
		for (int i = 0; i < tx_q.size() && i < exp_len; i++)
			compare_value($sformatf("{txp,txn} cycle %0d", i), tx_q[i],
				(i < drive_len) ? {mask, 8'h00} : {8'h00, mask});
		// acquisition, every window frame is either accepted or dropped
		n = acc_q.size();
		if (!back_pressure)
			compare_value("accepted frame count", n, samples);
		require_rule(n <= samples, "more frames accepted than the window holds");
		compare_value("reg_rdata status overflow", 32'(rd[2]), (n < samples) ? 1 : 0);
		for (int i = 1; i < n; i++)
		begin
			diff = int'(sample_t'(acc_q[i] - acc_q[i-1]));
			if (!back_pressure)
				compare_value("sample_data ch0 step", diff, 1);	// consecutive counts
			else
				require_rule(diff >= 1 && diff <= samples, "accepted frames do not rise strictly");
		end
	endtask

	// ==============================
	// main sequence and watchdog
	// ==============================
	initial
	begin
		reg_data_t rd;
		void'($urandom(32'h6add5b82));
		reg_wr         = 1'b0;
		reg_addr       = '0;
		reg_wdata      = '0;
		ready_random   = 1'b0;
		errors         = 0;
		checks         = 0;
		shot_bursts    = 0;
		total_bursts   = 0;
		total_active   = 0;
		exp_bursts     = 0;
		exp_active     = 0;
		tx_prev_active = 1'b0;
		stalled        = 1'b0;
		stall_data     = '0;
		do
			@(posedge ADC_CLKOUT);
		while (rst);
		for (int a = 1; a < 8; a++)
		begin
			read_reg(reg_addr_t'(a), rd);	// all zero after reset, status too
			compare_value($sformatf("reg_rdata[%0d]", a), rd, 32'h0);
		end
		for (int s = 0; s < NUM_SHOTS; s++)
			run_shot();
		repeat (64) @(negedge ADC_CLKOUT);	// late or extra bursts land here
		compare_value("total txp/txn bursts", total_bursts, exp_bursts);
		compare_value("total txp/txn active cycles", total_active, exp_active);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the DUT stopped responding", WATCHDOG_NS);
		$display("checks %0d, errors %0d", checks, errors);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- build.f
us_pkg.sv
us_cfg_if.sv
us_cfg_regs.sv
us_tx_pulser.sv
us_acq_sequencer.sv
us_sample_stream.sv
us_frontend_top.sv
tb_clk_gen.sv
tb_us_frontend.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_us_frontend -Mdir obj_dir -o tb_sim -f build.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1
